// ==== src.f ====
mem_pkg.sv
sdp_ram.sv
mem_bus_decode.sv
wr_pointer_regs.sv
pattern_store.sv
engine_readout.sv
memory_top.sv
tb_checker.sv
tb_memory.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_memory
SRC       ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(SRC) --top-module $(TOP) -Mdir $(OBJ_DIR) -o sim

# Status comes from the search for the pass line
run: build
	@out="$$($(OBJ_DIR)/sim)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(SRC) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_memory;

  localparam int clk_period = 8;
  localparam int max_steps = 128;

  typedef enum logic [2:0] {
    op_write, op_reg, op_read, op_delay, op_mod, op_stm
  } op_e;

  // Same codes as the checker's port case
  typedef enum logic [1:0] {
    port_data, port_delay, port_mod, port_stm
  } port_e;

  logic                               bus_clk;
  logic                               rst_n;
  logic                               en;
  logic                               we;
  mem_pkg::bank_e                     bank_sel;
  logic [mem_pkg::addr_w-1:0]         addr;
  logic [mem_pkg::data_w-1:0]         data_in;
  logic [mem_pkg::data_w-1:0]         data_out;
  logic [mem_pkg::ctl_aw-1:0]         delay_idx;
  logic [mem_pkg::data_w-1:0]         delay_value;
  logic [mem_pkg::mod_aw-1:0]         mod_idx;
  logic                               mod_segment;
  logic [mem_pkg::mod_data_w-1:0]     mod_value;
  logic [mem_pkg::stm_aw-1:0]         stm_idx;
  logic                               stm_segment;
  logic [mem_pkg::data_w-1:0]         stm_value;
  logic                               exp_valid;
  port_e                              exp_port;
  logic [mem_pkg::data_w-1:0]         exp_value;
  int                                 check_count;
  int                                 error_count;

  // Stimulus table
  op_e             t_op [max_steps];
  mem_pkg::bank_e  t_bank [max_steps];
  logic [13:0]     t_addr [max_steps];
  logic [15:0]     t_data [max_steps];
  logic            t_seg [max_steps];
  port_e           t_port [max_steps];
  logic [15:0]     t_value [max_steps];
  int              step_count;
  int              read_count;
  logic            table_ready;

  // Expected-value model of every region and pointer
  logic [15:0]  ctl_model [256];
  logic [15:0]  delay_model [256];
  logic [7:0]   mod_model [2][1024];
  logic [15:0]  stm_model [2][4096];
  logic         m_mod_seg;
  logic         m_stm_seg;
  logic [1:0]   m_page;
  logic [31:0]  lfsr;

  memory_top DUT (
    .bus_clk     (bus_clk),
    .rst_n       (rst_n),
    .en          (en),
    .we          (we),
    .bank_sel    (bank_sel),
    .addr        (addr),
    .data_in     (data_in),
    .data_out    (data_out),
    .delay_idx   (delay_idx),
    .delay_value (delay_value),
    .mod_idx     (mod_idx),
    .mod_segment (mod_segment),
    .mod_value   (mod_value),
    .stm_idx     (stm_idx),
    .stm_segment (stm_segment),
    .stm_value   (stm_value)
  );

  tb_checker u_checker (
    .bus_clk     (bus_clk),
    .exp_valid   (exp_valid),
    .exp_port    (exp_port),
    .exp_value   (exp_value),
    .data_out    (data_out),
    .delay_value (delay_value),
    .mod_value   (mod_value),
    .stm_value   (stm_value),
    .check_count (check_count),
    .error_count (error_count)
  );

  initial begin
    bus_clk = 1'b0;
    forever #(clk_period / 2) bus_clk = ~bus_clk;
  end

  // Taps 32, 22, 2, 1; one step per bit taken
  function automatic logic [15:0] rand_bits(input int nbits);
    logic [15:0] v;
    logic        fb;
    v = '0;
    for (int b = 0; b < nbits; b++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[14:0], fb};
    end
    return v;
  endfunction

  task automatic add_step(input op_e op, input mem_pkg::bank_e bank, input logic [13:0] a,
                          input logic [15:0] d, input logic seg, input port_e p,
                          input logic [15:0] v);
    t_op[step_count]    = op;
    t_bank[step_count]  = bank;
    t_addr[step_count]  = a;
    t_data[step_count]  = d;
    t_seg[step_count]   = seg;
    t_port[step_count]  = p;
    t_value[step_count] = v;
    step_count++;
  endtask

  // Single-cycle host write, pointers stay as they are
  task automatic host_write(input mem_pkg::bank_e bank, input logic [13:0] a,
                            input logic [15:0] d);
    case (bank)
      mem_pkg::bank_ctl: begin
        if (a[13:8] == 6'd0) ctl_model[a[7:0]] = d;
        else if (a[13:8] == 6'd1) delay_model[a[7:0]] = d;
      end
      mem_pkg::bank_mod: mod_model[m_mod_seg][a[9:0]] = d[7:0];
      mem_pkg::bank_stm: stm_model[m_stm_seg][{m_page, a[9:0]}] = d;
      default: begin
      end
    endcase
    add_step(op_write, bank, a, d, 1'b0, port_data, 16'h0);
  endtask

  // Two-cycle hold that loads a pointer register
  task automatic reg_write(input mem_pkg::ctl_reg_e r, input logic [15:0] d);
    ctl_model[r] = d;
    case (r)
      mem_pkg::reg_mod_wr_segment: m_mod_seg = d[0];
      mem_pkg::reg_stm_wr_segment: m_stm_seg = d[0];
      default: m_page = d[1:0];
    endcase
    add_step(op_reg, mem_pkg::bank_ctl, {6'd0, r}, d, 1'b0, port_data, 16'h0);
  endtask

  task automatic expect_read(input op_e op, input logic [13:0] a, input logic seg);
    logic [15:0] v;
    port_e       p;
    case (op)
      op_read: begin
        v = ctl_model[a[7:0]];
        p = port_data;
      end
      op_delay: begin
        v = delay_model[a[7:0]];
        p = port_delay;
      end
      op_mod: begin
        v = {8'h00, mod_model[seg][a[9:0]]};
        p = port_mod;
      end
      default: begin
        v = stm_model[seg][a[11:0]];
        p = port_stm;
      end
    endcase
    read_count++;
    add_step(op, mem_pkg::bank_ctl, a, 16'h0, seg, p, v);
  endtask

  task automatic build_table();
    logic [15:0] d;
    logic [9:0]  ma;
    // Reset state, segment 0 and page 0
    host_write(mem_pkg::bank_mod, 14'h0123, rand_bits(8));
    host_write(mem_pkg::bank_stm, 14'h0055, rand_bits(16));
    expect_read(op_mod, 14'h0123, 1'b0);
    expect_read(op_stm, 14'h0055, 1'b0);
    // Controller words, the first one written twice
    for (int k = 0; k < 6; k++) host_write(mem_pkg::bank_ctl, 14'(k * 9 + 2), rand_bits(16));
    host_write(mem_pkg::bank_ctl, 14'd2, rand_bits(16));
    for (int k = 0; k < 6; k++) expect_read(op_read, 14'(k * 9 + 2), 1'b0);
    // Delay region sits at addr[13:8] == 1
    for (int k = 0; k < 4; k++) host_write(mem_pkg::bank_ctl, 14'(256 + k * 21), rand_bits(16));
    for (int k = 0; k < 4; k++) expect_read(op_delay, 14'(k * 21), 1'b0);
    // Modulation segments, then reads alternating the segment
    for (int k = 0; k < 4; k++) host_write(mem_pkg::bank_mod, 14'(k * 64 + 7), rand_bits(8));
    reg_write(mem_pkg::reg_mod_wr_segment, 16'h0001);
    for (int k = 0; k < 4; k++) begin
      ma = 10'(k * 64 + 7);
      d = rand_bits(8);
      if (d[7:0] == mod_model[0][ma]) d = ~d;
      host_write(mem_pkg::bank_mod, 14'(ma), d);
    end
    for (int k = 0; k < 4; k++) begin
      expect_read(op_mod, 14'(k * 64 + 7), 1'b0);
      expect_read(op_mod, 14'(k * 64 + 7), 1'b1);
    end
    // Single-cycle pointer write only reaches the RAM word
    d = rand_bits(16) & 16'hfffe;
    host_write(mem_pkg::bank_ctl, {6'd0, mem_pkg::reg_mod_wr_segment}, d);
    expect_read(op_read, 14'h0040, 1'b0);
    host_write(mem_pkg::bank_mod, 14'd7, rand_bits(8));
    expect_read(op_mod, 14'd7, 1'b1);
    expect_read(op_mod, 14'd7, 1'b0);
    // Same STM address in every page of segment 1, one page of segment 0
    reg_write(mem_pkg::reg_stm_wr_segment, 16'h0001);
    for (int p = 0; p < 4; p++) begin
      reg_write(mem_pkg::reg_stm_wr_page, 16'(p));
      host_write(mem_pkg::bank_stm, 14'h0055, rand_bits(16));
    end
    reg_write(mem_pkg::reg_stm_wr_segment, 16'h0000);
    reg_write(mem_pkg::reg_stm_wr_page, 16'h0002);
    host_write(mem_pkg::bank_stm, 14'h0055, rand_bits(16));
    for (int p = 0; p < 4; p++) expect_read(op_stm, 14'(p * 1024 + 'h55), 1'b1);
    expect_read(op_stm, 14'h0855, 1'b0);
    expect_read(op_stm, 14'h0055, 1'b0);
    expect_read(op_read, 14'h0042, 1'b0);
  endtask

  task automatic drive_step(input int i);
    en = 1'b0;
    we = 1'b0;
    exp_valid = 1'b0;
    case (t_op[i])
      op_write, op_reg: begin
        en = 1'b1;
        we = 1'b1;
        bank_sel = t_bank[i];
        addr = t_addr[i];
        data_in = t_data[i];
      end
      op_read: begin
        en = 1'b1;
        bank_sel = mem_pkg::bank_ctl;
        addr = t_addr[i];
      end
      op_delay: delay_idx = t_addr[i][7:0];
      op_mod: begin
        mod_idx = t_addr[i][9:0];
        mod_segment = t_seg[i];
      end
      default: begin
        stm_idx = t_addr[i][11:0];
        stm_segment = t_seg[i];
      end
    endcase
    if (t_op[i] != op_write && t_op[i] != op_reg) begin
      exp_valid = 1'b1;
      exp_port = t_port[i];
      exp_value = t_value[i];
    end
  endtask

  task automatic bus_idle();
    en = 1'b0;
    we = 1'b0;
    exp_valid = 1'b0;
  endtask

  initial begin
    rst_n = 1'b0;
    en = 1'b0;
    we = 1'b0;
    bank_sel = mem_pkg::bank_none;
    addr = '0;
    data_in = '0;
    delay_idx = '0;
    mod_idx = '0;
    mod_segment = 1'b0;
    stm_idx = '0;
    stm_segment = 1'b0;
    exp_valid = 1'b0;
    exp_port = port_data;
    exp_value = '0;
    lfsr = 32'hc731;
    m_mod_seg = 1'b0;
    m_stm_seg = 1'b0;
    m_page = 2'd0;
    step_count = 0;
    read_count = 0;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (5) @(negedge bus_clk);
    rst_n = 1'b1;
    for (int i = 0; i < step_count; i++) begin
      if (t_op[i] == op_reg) begin
        // Idle before and after so the hold is seen as exactly two cycles
        bus_idle();
        @(negedge bus_clk);
        drive_step(i);
        repeat (2) @(negedge bus_clk);
        bus_idle();
        @(negedge bus_clk);
      end else begin
        drive_step(i);
        @(negedge bus_clk);
      end
    end
    bus_idle();
    repeat (3) @(negedge bus_clk);
    if (check_count != read_count) $display("Some expected reads were never checked");
    $display("Checks: %0d of %0d, errors: %0d", check_count, read_count, error_count);
    if (error_count == 0 && check_count == read_count) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Each table step needs at most four cycles
  initial begin
    int limit;
    wait (table_ready);
    limit = (step_count * 4 + 5 + 20) * clk_period;
    #(limit);
    $display("Timeout: the test sequence did not finish in time");
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  var logic                             bus_clk,
  input  var logic                             exp_valid,
  input  var logic [1:0]                       exp_port,
  input  var logic [mem_pkg::data_w-1:0]       exp_value,
  input  var logic [mem_pkg::data_w-1:0]       data_out,
  input  var logic [mem_pkg::data_w-1:0]       delay_value,
  input  var logic [mem_pkg::mod_data_w-1:0]   mod_value,
  input  var logic [mem_pkg::data_w-1:0]       stm_value,
  output int                                   check_count,
  output int                                   error_count
);

  logic                        pend_valid = 1'b0;
  logic [1:0]                  pend_port;
  logic [mem_pkg::data_w-1:0]  pend_value;
  logic [mem_pkg::data_w-1:0]  actual;
  string                       name;
  int                          checks = 0;
  int                          errors = 0;

  assign check_count = checks;
  assign error_count = errors;

  // Request is taken on the edge that also launches the DUT read
  always @(posedge bus_clk) begin
    pend_valid <= exp_valid;
    pend_port  <= exp_port;
    pend_value <= exp_value;
  end

  // All watched outputs are registered, so they are settled at the falling edge
  always @(negedge bus_clk) begin
    if (pend_valid) begin
      case (pend_port)
        2'd0: begin
          name   = "data_out";
          actual = data_out;
        end
        2'd1: begin
          name   = "delay_value";
          actual = delay_value;
        end
        2'd2: begin
          name   = "mod_value";
          actual = {8'h00, mod_value};
        end
        default: begin
          name   = "stm_value";
          actual = stm_value;
        end
      endcase
      checks++;
      if (actual !== pend_value) begin
        errors++;
        $display("error: %s expected 0x%h actual 0x%h", name, pend_value, actual);
      end
    end
  end

endmodule

`default_nettype wire

// ==== memory_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_top (
  input  var logic                              bus_clk,
  input  var logic                              rst_n,
  input  var logic                              en,
  input  var logic                              we,
  input  var mem_pkg::bank_e                    bank_sel,
  input  var logic [mem_pkg::addr_w-1:0]        addr,
  input  var logic [mem_pkg::data_w-1:0]        data_in,
  output logic [mem_pkg::data_w-1:0]            data_out,
  input  var logic [mem_pkg::ctl_aw-1:0]        delay_idx,
  output logic [mem_pkg::data_w-1:0]            delay_value,
  input  var logic [mem_pkg::mod_aw-1:0]        mod_idx,
  input  var logic                              mod_segment,
  output logic [mem_pkg::mod_data_w-1:0]        mod_value,
  input  var logic [mem_pkg::stm_aw-1:0]        stm_idx,
  input  var logic                              stm_segment,
  output logic [mem_pkg::data_w-1:0]            stm_value
);

  logic                               ctl_we;
  logic                               delay_we;
  logic                               mod_we;
  logic                               stm_we;
  logic                               ctl_rd;
  logic                               ctl_reg_wr;
  mem_pkg::ctl_reg_e                  reg_sel;
  logic [mem_pkg::data_w-1:0]         reg_data;
  logic [mem_pkg::mod_aw-1:0]         wr_addr;
  logic [mem_pkg::data_w-1:0]         wr_data;
  logic                               mod_wr_segment;
  logic                               stm_wr_segment;
  logic [mem_pkg::stm_page_w-1:0]     stm_wr_page;
  logic [mem_pkg::mod_data_w-1:0]     mod_value_0;
  logic [mem_pkg::mod_data_w-1:0]     mod_value_1;
  logic [mem_pkg::data_w-1:0]         stm_value_0;
  logic [mem_pkg::data_w-1:0]         stm_value_1;

  mem_bus_decode u_decode (
    .bus_clk    (bus_clk),
    .rst_n      (rst_n),
    .en         (en),
    .we         (we),
    .bank_sel   (bank_sel),
    .addr       (addr),
    .data_in    (data_in),
    .ctl_we     (ctl_we),
    .delay_we   (delay_we),
    .mod_we     (mod_we),
    .stm_we     (stm_we),
    .ctl_rd     (ctl_rd),
    .ctl_reg_wr (ctl_reg_wr),
    .reg_sel    (reg_sel),
    .reg_data   (reg_data),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data)
  );

  wr_pointer_regs u_pointers (
    .bus_clk        (bus_clk),
    .rst_n          (rst_n),
    .ctl_reg_wr     (ctl_reg_wr),
    .reg_sel        (reg_sel),
    .wr_data        (reg_data),
    .mod_wr_segment (mod_wr_segment),
    .stm_wr_segment (stm_wr_segment),
    .stm_wr_page    (stm_wr_page)
  );

  pattern_store u_store (
    .bus_clk        (bus_clk),
    .ctl_we         (ctl_we),
    .delay_we       (delay_we),
    .mod_we         (mod_we),
    .stm_we         (stm_we),
    .ctl_rd         (ctl_rd),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .mod_wr_segment (mod_wr_segment),
    .stm_wr_segment (stm_wr_segment),
    .stm_wr_page    (stm_wr_page),
    .delay_idx      (delay_idx),
    .mod_idx        (mod_idx),
    .stm_idx        (stm_idx),
    .ctl_rdata      (data_out),
    .delay_value    (delay_value),
    .mod_value_0    (mod_value_0),
    .mod_value_1    (mod_value_1),
    .stm_value_0    (stm_value_0),
    .stm_value_1    (stm_value_1)
  );

  engine_readout u_readout (
    .bus_clk     (bus_clk),
    .rst_n       (rst_n),
    .mod_segment (mod_segment),
    .stm_segment (stm_segment),
    .mod_value_0 (mod_value_0),
    .mod_value_1 (mod_value_1),
    .stm_value_0 (stm_value_0),
    .stm_value_1 (stm_value_1),
    .mod_value   (mod_value),
    .stm_value   (stm_value)
  );

endmodule

`default_nettype wire

// ==== engine_readout.sv ====
`timescale 1ns/1ps
`default_nettype none

module engine_readout (
  input  var logic                              bus_clk,
  input  var logic                              rst_n,
  input  var logic                              mod_segment,
  input  var logic                              stm_segment,
  input  var logic [mem_pkg::mod_data_w-1:0]    mod_value_0,
  input  var logic [mem_pkg::mod_data_w-1:0]    mod_value_1,
  input  var logic [mem_pkg::data_w-1:0]        stm_value_0,
  input  var logic [mem_pkg::data_w-1:0]        stm_value_1,
  output logic [mem_pkg::mod_data_w-1:0]        mod_value,
  output logic [mem_pkg::data_w-1:0]            stm_value
);

  logic mod_seg_q;
  logic stm_seg_q;

  // Segment choice follows its read through the RAM output register
  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      mod_seg_q <= 1'b0;
      stm_seg_q <= 1'b0;
    end else begin
      mod_seg_q <= mod_segment;
      stm_seg_q <= stm_segment;
    end
  end

  assign mod_value = mod_seg_q ? mod_value_1 : mod_value_0;
  assign stm_value = stm_seg_q ? stm_value_1 : stm_value_0;

endmodule

`default_nettype wire

// ==== pattern_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module pattern_store (
  input  var logic                              bus_clk,
  input  var logic                              ctl_we,
  input  var logic                              delay_we,
  input  var logic                              mod_we,
  input  var logic                              stm_we,
  input  var logic                              ctl_rd,
  input  var logic [mem_pkg::mod_aw-1:0]        wr_addr,
  input  var logic [mem_pkg::data_w-1:0]        wr_data,
  input  var logic                              mod_wr_segment,
  input  var logic                              stm_wr_segment,
  input  var logic [mem_pkg::stm_page_w-1:0]    stm_wr_page,
  input  var logic [mem_pkg::ctl_aw-1:0]        delay_idx,
  input  var logic [mem_pkg::mod_aw-1:0]        mod_idx,
  input  var logic [mem_pkg::stm_aw-1:0]        stm_idx,
  output logic [mem_pkg::data_w-1:0]            ctl_rdata,
  output logic [mem_pkg::data_w-1:0]            delay_value,
  output logic [mem_pkg::mod_data_w-1:0]        mod_value_0,
  output logic [mem_pkg::mod_data_w-1:0]        mod_value_1,
  output logic [mem_pkg::data_w-1:0]            stm_value_0,
  output logic [mem_pkg::data_w-1:0]            stm_value_1
);

  logic [mem_pkg::ctl_aw-1:0]     ctl_addr;
  logic [mem_pkg::stm_aw-1:0]     stm_waddr;
  logic [mem_pkg::mod_data_w-1:0] mod_wdata;

  assign ctl_addr  = wr_addr[mem_pkg::ctl_aw-1:0];
  assign stm_waddr = {stm_wr_page, wr_addr};
  assign mod_wdata = wr_data[mem_pkg::mod_data_w-1:0];

  // Host writes and reads back at the same address
  sdp_ram #(.width(mem_pkg::data_w), .depth(mem_pkg::ctl_depth)) u_ctl_ram (
    .bus_clk (bus_clk),
    .we      (ctl_we),
    .waddr   (ctl_addr),
    .wdata   (wr_data),
    .re      (ctl_rd),
    .raddr   (ctl_addr),
    .rdata   (ctl_rdata)
  );

  sdp_ram #(.width(mem_pkg::data_w), .depth(mem_pkg::ctl_depth)) u_delay_ram (
    .bus_clk (bus_clk),
    .we      (delay_we),
    .waddr   (ctl_addr),
    .wdata   (wr_data),
    .re      (1'b1),
    .raddr   (delay_idx),
    .rdata   (delay_value)
  );

  // Modulation segments, write steered by the segment pointer
  sdp_ram #(.width(mem_pkg::mod_data_w), .depth(mem_pkg::mod_depth)) u_mod_ram_0 (
    .bus_clk (bus_clk),
    .we      (mod_we & ~mod_wr_segment),
    .waddr   (wr_addr),
    .wdata   (mod_wdata),
    .re      (1'b1),
    .raddr   (mod_idx),
    .rdata   (mod_value_0)
  );

  sdp_ram #(.width(mem_pkg::mod_data_w), .depth(mem_pkg::mod_depth)) u_mod_ram_1 (
    .bus_clk (bus_clk),
    .we      (mod_we & mod_wr_segment),
    .waddr   (wr_addr),
    .wdata   (mod_wdata),
    .re      (1'b1),
    .raddr   (mod_idx),
    .rdata   (mod_value_1)
  );

  // STM segments, page pointer supplies the upper address bits
  sdp_ram #(.width(mem_pkg::data_w), .depth(mem_pkg::stm_depth)) u_stm_ram_0 (
    .bus_clk (bus_clk),
    .we      (stm_we & ~stm_wr_segment),
    .waddr   (stm_waddr),
    .wdata   (wr_data),
    .re      (1'b1),
    .raddr   (stm_idx),
    .rdata   (stm_value_0)
  );

  sdp_ram #(.width(mem_pkg::data_w), .depth(mem_pkg::stm_depth)) u_stm_ram_1 (
    .bus_clk (bus_clk),
    .we      (stm_we & stm_wr_segment),
    .waddr   (stm_waddr),
    .wdata   (wr_data),
    .re      (1'b1),
    .raddr   (stm_idx),
    .rdata   (stm_value_1)
  );

endmodule

`default_nettype wire

// ==== wr_pointer_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module wr_pointer_regs (
  input  var logic                             bus_clk,
  input  var logic                             rst_n,
  input  var logic                             ctl_reg_wr,
  input  var mem_pkg::ctl_reg_e                reg_sel,
  input  var logic [mem_pkg::data_w-1:0]       wr_data,
  output logic                                 mod_wr_segment,
  output logic                                 stm_wr_segment,
  output logic [mem_pkg::stm_page_w-1:0]       stm_wr_page
);

  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      mod_wr_segment <= 1'b0;
      stm_wr_segment <= 1'b0;
      stm_wr_page    <= '0;
    end else if (ctl_reg_wr) begin
      case (reg_sel)
        mem_pkg::reg_mod_wr_segment: mod_wr_segment <= wr_data[0];
        mem_pkg::reg_stm_wr_segment: stm_wr_segment <= wr_data[0];
        mem_pkg::reg_stm_wr_page:    stm_wr_page <= wr_data[mem_pkg::stm_page_w-1:0];
        default: begin
        end
      endcase
    end
  end

  // Decode only strobes for mapped pointer addresses
  a_legal_sel: assert property (@(posedge bus_clk) disable iff (!rst_n)
    ctl_reg_wr |-> (reg_sel inside {mem_pkg::reg_mod_wr_segment,
                                    mem_pkg::reg_stm_wr_segment,
                                    mem_pkg::reg_stm_wr_page}));

endmodule

`default_nettype wire

// ==== mem_bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_bus_decode (
  input  var logic                          bus_clk,
  input  var logic                          rst_n,
  input  var logic                          en,
  input  var logic                          we,
  input  var mem_pkg::bank_e                bank_sel,
  input  var logic [mem_pkg::addr_w-1:0]    addr,
  input  var logic [mem_pkg::data_w-1:0]    data_in,
  output logic                              ctl_we,
  output logic                              delay_we,
  output logic                              mod_we,
  output logic                              stm_we,
  output logic                              ctl_rd,
  output logic                              ctl_reg_wr,
  output mem_pkg::ctl_reg_e                 reg_sel,
  output logic [mem_pkg::data_w-1:0]        reg_data,
  output logic [mem_pkg::mod_aw-1:0]        wr_addr,
  output logic [mem_pkg::data_w-1:0]        wr_data
);

  logic              wr_cyc;
  logic              rd_cyc;
  logic              ctl_hit;
  logic              delay_hit;
  logic              mod_hit;
  logic              stm_hit;
  mem_pkg::region_e  region;
  logic [2:0]        wr_hist;
  logic [7:0]        sel_q;
  logic              sel_is_reg;

  assign wr_cyc = en & we;
  assign rd_cyc = en & ~we;
  assign region = mem_pkg::region_e'(addr[mem_pkg::addr_w-1:8]);

  always_comb begin
    ctl_hit   = 1'b0;
    delay_hit = 1'b0;
    mod_hit   = 1'b0;
    stm_hit   = 1'b0;
    case (bank_sel)
      mem_pkg::bank_ctl: begin
        ctl_hit   = (region == mem_pkg::region_ctl);
        delay_hit = (region == mem_pkg::region_delay);
      end
      mem_pkg::bank_mod: mod_hit = 1'b1;
      mem_pkg::bank_stm: stm_hit = 1'b1;
      mem_pkg::bank_none: begin
        // Unmapped bank drops the cycle
      end
    endcase
  end

  assign ctl_we   = wr_cyc & ctl_hit;
  assign delay_we = wr_cyc & delay_hit;
  assign mod_we   = wr_cyc & mod_hit;
  assign stm_we   = wr_cyc & stm_hit;
  assign ctl_rd   = rd_cyc & ctl_hit;
  assign wr_addr  = addr[mem_pkg::mod_aw-1:0];
  assign wr_data  = data_in;

  // Shift history of controller writes with the newest in bit 0
  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      wr_hist <= 3'b000;
    end else begin
      wr_hist <= {wr_hist[1:0], ctl_we};
    end
  end

  // Register address and data of the write that completes a hold
  always_ff @(posedge bus_clk) begin
    if (ctl_we) begin
      sel_q    <= addr[7:0];
      reg_data <= data_in;
    end
  end

  assign reg_sel    = mem_pkg::ctl_reg_e'(sel_q);
  assign sel_is_reg = reg_sel inside {mem_pkg::reg_mod_wr_segment,
                                      mem_pkg::reg_stm_wr_segment,
                                      mem_pkg::reg_stm_wr_page};

  // Two held cycles preceded by an idle one, so a longer hold strobes once
  assign ctl_reg_wr = (wr_hist == 3'b011) & sel_is_reg;

  a_one_region: assert property (@(posedge bus_clk) disable iff (!rst_n)
    $onehot0({ctl_we, delay_we, mod_we, stm_we}));

endmodule

`default_nettype wire

// ==== sdp_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdp_ram #(
  parameter int width = 16,
  parameter int depth = 256
) (
  input  var logic                     bus_clk,
  input  var logic                     we,
  input  var logic [$clog2(depth)-1:0] waddr,
  input  var logic [width-1:0]         wdata,
  input  var logic                     re,
  input  var logic [$clog2(depth)-1:0] raddr,
  output logic     [width-1:0]         rdata
);

  logic [width-1:0] mem [depth];

  always_ff @(posedge bus_clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Output register holds its value between reads
  always_ff @(posedge bus_clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  // Host bus geometry
  localparam int data_w = 16;
  localparam int addr_w = 14;

  // Controller and delay regions share the same depth
  localparam int ctl_depth = 256;
  localparam int ctl_aw = $clog2(ctl_depth);

  // Modulation segment holds 8-bit samples
  localparam int mod_depth = 1024;
  localparam int mod_data_w = 8;
  localparam int mod_aw = $clog2(mod_depth);

  // STM segment is split into pages of equal size
  localparam int stm_page_depth = 1024;
  localparam int stm_pages = 4;
  localparam int stm_page_w = $clog2(stm_pages);
  localparam int stm_depth = stm_pages * stm_page_depth;
  localparam int stm_aw = $clog2(stm_depth);

  typedef enum logic [1:0] {
    bank_ctl  = 2'd0,
    bank_mod  = 2'd1,
    bank_stm  = 2'd2,
    bank_none = 2'd3
  } bank_e;

  // Sub-region inside the controller bank, from addr[13:8]
  typedef enum logic [5:0] {
    region_ctl   = 6'd0,
    region_delay = 6'd1
  } region_e;

  // Pointer registers mapped into the controller RAM
  typedef enum logic [7:0] {
    reg_mod_wr_segment = 8'h40,
    reg_stm_wr_segment = 8'h41,
    reg_stm_wr_page    = 8'h42
  } ctl_reg_e;

endpackage

`default_nettype wire
